//--- verilog/mem_cfg_pkg.sv
// default memory geometry shared by the memory subsystem

// ####################
// memory sizes
// ####################

package mem_cfg_pkg;

   // one word of the array
   parameter int DEF_DW    = 32;   // data width in bits

   // words in the array, keep it a power of two
   parameter int DEF_DEPTH = 16;   // number of words

endpackage : mem_cfg_pkg

//--- verilog/mem_ctrl_pkg.sv
// opcode, command fsm and bist fsm encodings for the memory subsystem

// ####################
// host command opcode
// ####################

package mem_ctrl_pkg;

   typedef enum logic {
      op_write = 1'b0,   // masked write of one word
      op_read  = 1'b1    // read, data comes back on rsp channel
   } cmd_op_e;

   // ####################
   // command stage fsm
   // ####################

   typedef enum logic [1:0] {
      cs_idle    = 2'd0,   // waiting for cmd_req
      cs_ack     = 2'd1,   // access issued, ack held high
      cs_release = 2'd2    // ack dropped, one gap cycle
   } cmd_state_e;

   // ####################
   // march bist phases
   // ####################

   typedef enum logic [2:0] {
      bs_idle  = 3'd0,   // waiting for bist_start
      bs_w0    = 3'd1,   // write 0, up
      bs_r0w1  = 3'd2,   // read 0 write 1, up
      bs_r1w0  = 3'd3,   // read 1 write 0, down
      bs_r0    = 3'd4,   // read 0, up
      bs_done  = 3'd5    // drain last compare
   } bist_state_e;

endpackage : mem_ctrl_pkg

//--- verilog/memory_ram.sv
// behavioral dual-port ram with per-bit write mask and registered read port
`timescale 1ns/1ps

module memory_ram #(
   parameter int  DW    = mem_cfg_pkg::DEF_DW,      // word width
   parameter int  DEPTH = mem_cfg_pkg::DEF_DEPTH,   // words
   localparam int AW    = $clog2(DEPTH)             // address width
) (
   // write port
   input  logic          wr_clk,    // write clock
   input  logic          wr_en,     // write enable
   input  logic [DW-1:0] wr_wem,    // per bit write enable
   input  logic [AW-1:0] wr_addr,   // write address
   input  logic [DW-1:0] wr_din,    // write data
   // read port
   input  logic          rd_clk,    // read clock
   input  logic          rd_en,     // read enable
   input  logic [AW-1:0] rd_addr,   // read address
   output logic [DW-1:0] rd_dout    // registered read data
);

   logic [DW-1:0] mem [DEPTH];   // storage array

   // ####################
   // write port
   // ####################

   // only bits with their mask bit set are replaced
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= (mem[wr_addr] & ~wr_wem) | (wr_din & wr_wem);   // masked merge
      end
   end

   // ####################
   // read port
   // ####################

   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_dout <= mem[rd_addr];   // old word on same-edge write
      end
   end

endmodule : memory_ram

//--- verilog/memory_dp.sv
// dual-port memory wrapper, hands the array to the bist ports when bist is enabled
`timescale 1ns/1ps

module memory_dp #(
   parameter int  DW    = mem_cfg_pkg::DEF_DW,      // word width
   parameter int  DEPTH = mem_cfg_pkg::DEF_DEPTH,   // words
   localparam int AW    = $clog2(DEPTH)             // address width
) (
   // host write port
   input  logic          wr_clk,         // write clock
   input  logic          wr_en,          // write enable
   input  logic [DW-1:0] wr_wem,         // per bit write enable
   input  logic [AW-1:0] wr_addr,        // write address
   input  logic [DW-1:0] wr_din,         // write data
   // host read port
   input  logic          rd_clk,         // read clock
   input  logic          rd_en,          // read enable
   input  logic [AW-1:0] rd_addr,        // read address
   output logic [DW-1:0] rd_dout,        // read data, shared with bist
   // bist ports
   input  logic          bist_en,        // bist owns the array
   input  logic          bist_we,        // bist write enable
   input  logic [DW-1:0] bist_wem,       // bist write mask
   input  logic [AW-1:0] bist_addr,      // bist write address
   input  logic [DW-1:0] bist_din,       // bist write data
   input  logic          bist_rd_en,     // bist read enable
   input  logic [AW-1:0] bist_rd_addr    // bist read address
);

   logic          ram_wr_en;     // muxed write enable
   logic [DW-1:0] ram_wr_wem;    // muxed mask
   logic [AW-1:0] ram_wr_addr;   // muxed write address
   logic [DW-1:0] ram_wr_din;    // muxed write data
   logic          ram_rd_en;     // muxed read enable
   logic [AW-1:0] ram_rd_addr;   // muxed read address

   // ####################
   // port select
   // ####################

   // host ports are ignored entirely while bist_en is high
   assign ram_wr_en   = bist_en ? bist_we      : wr_en;
   assign ram_wr_wem  = bist_en ? bist_wem     : wr_wem;
   assign ram_wr_addr = bist_en ? bist_addr    : wr_addr;
   assign ram_wr_din  = bist_en ? bist_din     : wr_din;
   assign ram_rd_en   = bist_en ? bist_rd_en   : rd_en;
   assign ram_rd_addr = bist_en ? bist_rd_addr : rd_addr;

   memory_ram #(
      .DW    (DW),
      .DEPTH (DEPTH)
   ) u_ram (
      .wr_clk  (wr_clk),
      .wr_en   (ram_wr_en),
      .wr_wem  (ram_wr_wem),
      .wr_addr (ram_wr_addr),
      .wr_din  (ram_wr_din),
      .rd_clk  (rd_clk),
      .rd_en   (ram_rd_en),
      .rd_addr (ram_rd_addr),
      .rd_dout (rd_dout)
   );

endmodule : memory_dp

//--- verilog/cmd_stage.sv
// four-phase command receiver, issues one memory access per host command
`timescale 1ns/1ps

module cmd_stage #(
   parameter int  DW    = mem_cfg_pkg::DEF_DW,      // word width
   parameter int  DEPTH = mem_cfg_pkg::DEF_DEPTH,   // words
   localparam int AW    = $clog2(DEPTH)             // address width
) (
   input  logic                  clk,         // core clock
   input  logic                  rst_n,       // sync reset, active low
   // host command channel
   input  logic                  cmd_req,     // four-phase request
   input  mem_ctrl_pkg::cmd_op_e cmd_op,      // write or read
   input  logic [AW-1:0]         cmd_addr,    // word address
   input  logic [DW-1:0]         cmd_wem,     // per bit write mask
   input  logic [DW-1:0]         cmd_din,     // write data
   output logic                  cmd_ack,     // four-phase acknowledge
   // hold-off sources
   input  logic                  bist_busy,   // bist owns memory
   input  logic                  rsp_busy,    // read response in flight
   // host memory ports
   output logic                  wr_en,       // one-cycle write pulse
   output logic [AW-1:0]         wr_addr,     // write address
   output logic [DW-1:0]         wr_wem,      // write mask
   output logic [DW-1:0]         wr_din,      // write data
   output logic                  rd_en,       // one-cycle read pulse
   output logic [AW-1:0]         rd_addr      // read address
);

   import mem_ctrl_pkg::*;

   cmd_state_e state;   // handshake state
   logic       go;      // command may be issued now

   // reads also wait for the response side, writes only for bist
   assign go = cmd_req && !bist_busy && (cmd_op == op_write || !rsp_busy);

   // ####################
   // handshake fsm
   // ####################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= cs_idle;
         cmd_ack <= 1'b0;
         wr_en   <= 1'b0;
         rd_en   <= 1'b0;
      end else begin
         wr_en <= 1'b0;   // pulses last one cycle
         rd_en <= 1'b0;
         case (state)
            cs_idle: begin
               if (go) begin
                  state   <= cs_ack;
                  cmd_ack <= 1'b1;                  // ack with the access
                  wr_en   <= (cmd_op == op_write);
                  rd_en   <= (cmd_op == op_read);
               end
            end
            cs_ack: begin
               if (!cmd_req) begin
                  state   <= cs_release;
                  cmd_ack <= 1'b0;                  // host has let go
               end
            end
            cs_release: state <= cs_idle;           // gap before next req
            default:    state <= cs_idle;
         endcase
      end
   end

   // ####################
   // access fields
   // ####################

   // fields are frozen once the command leaves idle
   always_ff @(posedge clk) begin
      if (state == cs_idle) begin
         wr_addr <= cmd_addr;
         rd_addr <= cmd_addr;
         wr_wem  <= cmd_wem;
         wr_din  <= cmd_din;
      end
   end

endmodule : cmd_stage

//--- verilog/bist_march.sv
// march bist engine, drives the bist memory ports and checks the read data
`timescale 1ns/1ps

module bist_march #(
   parameter int  DW    = mem_cfg_pkg::DEF_DW,      // word width
   parameter int  DEPTH = mem_cfg_pkg::DEF_DEPTH,   // words
   localparam int AW    = $clog2(DEPTH)             // address width
) (
   input  logic          clk,            // core clock
   input  logic          rst_n,          // sync reset, active low
   input  logic          bist_start,     // level, sampled in idle
   input  logic [DW-1:0] rd_dout,        // array read data
   output logic          bist_en,        // take over the array
   output logic          bist_we,        // write enable
   output logic [DW-1:0] bist_wem,       // write mask
   output logic [AW-1:0] bist_addr,      // write address
   output logic [DW-1:0] bist_din,       // write data
   output logic          bist_rd_en,     // read enable
   output logic [AW-1:0] bist_rd_addr,   // read address
   output logic          bist_busy,      // run in progress
   output logic          bist_done,      // held until next start
   output logic          bist_fail       // sticky for the run
);

   import mem_ctrl_pkg::*;

   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);   // top word

   bist_state_e   state;     // march phase
   logic [AW-1:0] addr;      // current march address
   logic          rd_exp;    // expected bit, aligned with bist_rd_en
   logic          chk;       // read data due this cycle
   logic          chk_exp;   // expected bit, aligned with chk

   assign bist_wem = {DW{1'b1}};   // march writes whole words

   // ####################
   // march sequencer
   // ####################

   // bist_en rises one cycle after bist_busy, so a host access
   // issued on the start edge still finishes on the host ports
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= bs_idle;
         addr       <= '0;
         bist_en    <= 1'b0;
         bist_we    <= 1'b0;
         bist_rd_en <= 1'b0;
         chk        <= 1'b0;
         bist_busy  <= 1'b0;
         bist_done  <= 1'b0;
         bist_fail  <= 1'b0;
      end else begin
         bist_we    <= 1'b0;
         bist_rd_en <= 1'b0;
         chk        <= bist_rd_en;                      // data one cycle later
         if (chk && rd_dout != {DW{chk_exp}}) begin
            bist_fail <= 1'b1;                          // any bit off
         end
         case (state)
            bs_idle: begin
               if (bist_start) begin
                  state     <= bs_w0;
                  addr      <= '0;
                  bist_busy <= 1'b1;
                  bist_done <= 1'b0;
                  bist_fail <= 1'b0;
               end
            end
            bs_w0: begin
               bist_en <= 1'b1;
               bist_we <= 1'b1;
               if (addr == LAST_ADDR) begin
                  state <= bs_r0w1;
                  addr  <= '0;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            bs_r0w1: begin
               bist_rd_en <= 1'b1;                      // read before write
               bist_we    <= 1'b1;
               if (addr == LAST_ADDR) begin
                  state <= bs_r1w0;
                  addr  <= LAST_ADDR;                   // descend next
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            bs_r1w0: begin
               bist_rd_en <= 1'b1;
               bist_we    <= 1'b1;
               if (addr == '0) begin
                  state <= bs_r0;
               end else begin
                  addr <= addr - 1'b1;
               end
            end
            bs_r0: begin
               bist_rd_en <= 1'b1;
               if (addr == LAST_ADDR) begin
                  state <= bs_done;
               end else begin
                  addr <= addr + 1'b1;
               end
            end
            bs_done: begin
               if (!bist_rd_en && !chk) begin           // last compare finished
                  state     <= bs_idle;
                  bist_en   <= 1'b0;
                  bist_busy <= 1'b0;
                  bist_done <= 1'b1;
               end
            end
            default: state <= bs_idle;
         endcase
      end
   end

   // ####################
   // port data
   // ####################

   always_ff @(posedge clk) begin
      bist_addr    <= addr;
      bist_rd_addr <= addr;
      bist_din     <= {DW{state == bs_r0w1}};   // ones only in r0w1
      rd_exp       <= (state == bs_r1w0);       // ones expected only in r1w0
      chk_exp      <= rd_exp;
   end

endmodule : bist_march

//--- verilog/read_return.sv
// read-return stage, holds read data and returns it over a four-phase channel
`timescale 1ns/1ps

module read_return #(
   parameter int DW = mem_cfg_pkg::DEF_DW   // word width
) (
   input  logic          clk,        // core clock
   input  logic          rst_n,      // sync reset, active low
   input  logic          rd_en,      // host read issued
   input  logic [DW-1:0] rd_dout,    // array read data
   input  logic          rsp_ack,    // four-phase acknowledge
   output logic          rsp_req,    // four-phase request
   output logic [DW-1:0] rsp_data,   // holding register
   output logic          rsp_busy    // response path occupied
);

   logic rd_d;   // rd_dout valid this cycle
   logic pend;   // captured, request next cycle

   // ####################
   // response handshake
   // ####################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_d    <= 1'b0;
         pend    <= 1'b0;
         rsp_req <= 1'b0;
      end else begin
         rd_d <= rd_en;                  // follows the ram read latency
         pend <= rd_d;
         if (pend) begin
            rsp_req <= 1'b1;
         end else if (rsp_ack) begin
            rsp_req <= 1'b0;             // host has taken the data
         end
      end
   end

   // data stays put until the next read is let through
   always_ff @(posedge clk) begin
      if (rd_d) begin
         rsp_data <= rd_dout;
      end
   end

   // busy until the host drops rsp_ack
   assign rsp_busy = rd_en | rd_d | pend | rsp_req | rsp_ack;

endmodule : read_return

//--- verilog/mem_subsys_top.sv
// memory subsystem top, command stage, dual-port memory, read return and bist
`timescale 1ns/1ps

module mem_subsys_top #(
   parameter int  DW    = mem_cfg_pkg::DEF_DW,      // word width
   parameter int  DEPTH = mem_cfg_pkg::DEF_DEPTH,   // words
   localparam int AW    = $clog2(DEPTH)             // address width
) (
   input  logic                  clk,          // single clock, both ports
   input  logic                  rst_n,        // sync reset, active low
   // host command channel
   input  logic                  cmd_req,
   input  mem_ctrl_pkg::cmd_op_e cmd_op,
   input  logic [AW-1:0]         cmd_addr,
   input  logic [DW-1:0]         cmd_wem,
   input  logic [DW-1:0]         cmd_din,
   output logic                  cmd_ack,
   // response channel
   output logic                  rsp_req,
   output logic [DW-1:0]         rsp_data,
   input  logic                  rsp_ack,
   // bist control
   input  logic                  bist_start,
   output logic                  bist_busy,
   output logic                  bist_done,
   output logic                  bist_fail
);

   // ####################
   // internal wiring
   // ####################

   logic          wr_en;          // host write pulse
   logic [AW-1:0] wr_addr;
   logic [DW-1:0] wr_wem;
   logic [DW-1:0] wr_din;
   logic          rd_en;          // host read pulse
   logic [AW-1:0] rd_addr;
   logic [DW-1:0] rd_dout;        // to read return and bist
   logic          rsp_busy;       // read path hold-off
   logic          bist_en;        // bist owns the array
   logic          bist_we;
   logic [DW-1:0] bist_wem;
   logic [AW-1:0] bist_addr;
   logic [DW-1:0] bist_din;
   logic          bist_rd_en;
   logic [AW-1:0] bist_rd_addr;

   cmd_stage #(.DW(DW), .DEPTH(DEPTH)) u_cmd (
      .clk      (clk),      .rst_n     (rst_n),
      .cmd_req  (cmd_req),  .cmd_op    (cmd_op),
      .cmd_addr (cmd_addr), .cmd_wem   (cmd_wem),
      .cmd_din  (cmd_din),  .cmd_ack   (cmd_ack),
      .bist_busy(bist_busy),.rsp_busy  (rsp_busy),
      .wr_en    (wr_en),    .wr_addr   (wr_addr),
      .wr_wem   (wr_wem),   .wr_din    (wr_din),
      .rd_en    (rd_en),    .rd_addr   (rd_addr)
   );

   // both ports run on the one core clock
   memory_dp #(.DW(DW), .DEPTH(DEPTH)) u_mem (
      .wr_clk   (clk),      .wr_en     (wr_en),
      .wr_wem   (wr_wem),   .wr_addr   (wr_addr),
      .wr_din   (wr_din),   .rd_clk    (clk),
      .rd_en    (rd_en),    .rd_addr   (rd_addr),
      .rd_dout  (rd_dout),  .bist_en   (bist_en),
      .bist_we  (bist_we),  .bist_wem  (bist_wem),
      .bist_addr(bist_addr),.bist_din  (bist_din),
      .bist_rd_en(bist_rd_en), .bist_rd_addr(bist_rd_addr)
   );

   read_return #(.DW(DW)) u_rsp (
      .clk      (clk),      .rst_n     (rst_n),
      .rd_en    (rd_en),    .rd_dout   (rd_dout),
      .rsp_ack  (rsp_ack),  .rsp_req   (rsp_req),
      .rsp_data (rsp_data), .rsp_busy  (rsp_busy)
   );

   bist_march #(.DW(DW), .DEPTH(DEPTH)) u_bist (
      .clk      (clk),      .rst_n     (rst_n),
      .bist_start(bist_start), .rd_dout(rd_dout),
      .bist_en  (bist_en),  .bist_we   (bist_we),
      .bist_wem (bist_wem), .bist_addr (bist_addr),
      .bist_din (bist_din), .bist_rd_en(bist_rd_en),
      .bist_rd_addr(bist_rd_addr), .bist_busy(bist_busy),
      .bist_done(bist_done),.bist_fail (bist_fail)
   );

endmodule : mem_subsys_top

//--- verification/tb_clkgen.sv
// testbench clock and synchronous reset source
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int RST_CYCLES = 3   // reset length in clocks
) (
   output logic clk,     // 4 ns core clock
   output logic rst_n    // active low, released after reset
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 2 ns half period
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;         // lines up with the other inputs
   end

endmodule : tb_clkgen

//--- verification/mem_subsys_chk.sv
// bound assertions for the command and response handshakes and bist port ownership
`timescale 1ns/1ps

module mem_subsys_chk (
   input logic clk,       // core clock
   input logic rst_n,     // sync reset, active low
   input logic cmd_req,   // host request
   input logic cmd_ack,   // command acknowledge
   input logic rsp_req,   // response request
   input logic rsp_ack,   // host response acknowledge
   input logic wr_en,     // host write pulse
   input logic rd_en,     // host read pulse
   input logic bist_en    // bist owns the array
);

   int n_fails = 0;   // failed assertion count

   // ack only ever answers a request seen at the edge before
   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_ack) |-> $past(cmd_req))
      else begin
         n_fails++;
         $error("cmd_ack rose while cmd_req was low");
      end

   // response request is held until the host acks
   rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_req && !rsp_ack |=> rsp_req)
      else begin
         n_fails++;
         $error("rsp_req dropped before rsp_ack");
      end

   // no host access reaches the ports once bist has them
   port_owner: assert property (@(posedge clk) disable iff (!rst_n)
      bist_en |-> !wr_en && !rd_en)
      else begin
         n_fails++;
         $error("host access pulsed while bist_en was high");
      end

endmodule : mem_subsys_chk

bind mem_subsys_top mem_subsys_chk u_chk (
   .clk     (clk),
   .rst_n   (rst_n),
   .cmd_req (cmd_req),
   .cmd_ack (cmd_ack),
   .rsp_req (rsp_req),
   .rsp_ack (rsp_ack),
   .wr_en   (wr_en),
   .rd_en   (rd_en),
   .bist_en (bist_en)
);

//--- verification/mem_subsys_tb.sv
// memory subsystem testbench, random commands against a word model, bist runs, timeout
`timescale 1ns/1ps

module mem_subsys_tb;

   import mem_cfg_pkg::*;
   import mem_ctrl_pkg::*;

   localparam int DW       = DEF_DW;          // word width
   localparam int DEPTH    = DEF_DEPTH;       // words
   localparam int AW       = $clog2(DEPTH);   // address width
   localparam int NUM_RAND = 16;              // random pairs per test
   localparam int NUM_PIPE = 8;               // overlapped read/write rounds
   localparam int NUM_CMDS = 3 * DEPTH + 4 * NUM_RAND + 4 * NUM_PIPE + 4;
   localparam int LIMIT    = 20 * NUM_CMDS + 3 * 8 * DEPTH + 100;   // three bist runs

   logic          clk, rst_n;
   logic          cmd_req, cmd_ack, rsp_req, rsp_ack;
   cmd_op_e       cmd_op;
   logic [AW-1:0] cmd_addr;
   logic [DW-1:0] cmd_wem, cmd_din, rsp_data;
   logic          bist_start, bist_busy, bist_done, bist_fail;

   logic [DW-1:0] model [DEPTH];   // expected array contents
   integer        seed = 75;
   int            cyc = 0;         // edges since time zero
   int            req_cyc;         // cyc when the last cmd_req rose
   int            n_checks = 0;
   int            n_errors = 0;

   tb_clkgen u_clk (.clk(clk), .rst_n(rst_n));

   mem_subsys_top #(.DW(DW), .DEPTH(DEPTH)) dut (
      .clk(clk), .rst_n(rst_n),
      .cmd_req(cmd_req), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
      .cmd_wem(cmd_wem), .cmd_din(cmd_din), .cmd_ack(cmd_ack),
      .rsp_req(rsp_req), .rsp_data(rsp_data), .rsp_ack(rsp_ack),
      .bist_start(bist_start), .bist_busy(bist_busy),
      .bist_done(bist_done), .bist_fail(bist_fail)
   );

   // ####################
   // helpers
   // ####################

   task automatic check(input string name, input logic [DW-1:0] exp,
                        input logic [DW-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;   // outputs settled, inputs driven here
   endtask

   // full four-phase command, returns once cmd_ack is low again
   task automatic send_cmd(input cmd_op_e op, input logic [AW-1:0] addr,
                           input logic [DW-1:0] wem, input logic [DW-1:0] din);
      cmd_op   = op;
      cmd_addr = addr;
      cmd_wem  = wem;
      cmd_din  = din;
      cmd_req  = 1'b1;
      req_cyc  = cyc;
      do next_cycle(); while (!cmd_ack);
      check("ack_after_bist", '0, DW'(bist_busy));   // never acked under bist
      cmd_req = 1'b0;
      do next_cycle(); while (cmd_ack);
      if (op == op_write) begin
         for (int k = 0; k < DW; k++) begin
            if (wem[k]) begin
               model[addr][k] = din[k];   // unmasked bits keep their value
            end
         end
      end
   endtask

   // response side with a random 0..3 cycle delay before rsp_ack
   task automatic collect_rsp(input string name, input logic [DW-1:0] exp,
                              input bit timed);
      int dly;
      dly = $unsigned($random(seed)) % 4;
      while (!rsp_req) next_cycle();
      if (timed) begin
         check({name, "_latency"}, 3, DW'(cyc - req_cyc - 1));   // from sampling edge
      end
      repeat (dly) begin
         next_cycle();
         check({name, "_req_hold"}, 1, DW'(rsp_req));
         check({name, "_data_hold"}, exp, rsp_data);
      end
      check(name, exp, rsp_data);
      rsp_ack = 1'b1;
      do next_cycle(); while (rsp_req);
      rsp_ack = 1'b0;
   endtask

   task automatic read_check(input string name, input logic [AW-1:0] addr);
      send_cmd(op_read, addr, '0, '0);
      collect_rsp(name, model[addr], 1'b0);
   endtask

   // march leaves zeros behind, so the model is cleared at start
   task automatic start_bist();
      bist_start = 1'b1;
      do next_cycle(); while (!bist_busy);
      bist_start = 1'b0;
      for (int i = 0; i < DEPTH; i++) model[i] = '0;
   endtask

   task automatic finish_bist();
      while (bist_busy) next_cycle();
      check("bist_done", 1, DW'(bist_done));
      check("bist_fail", 0, DW'(bist_fail));
   endtask

   function automatic logic [AW-1:0] rand_addr();
      return AW'($unsigned($random(seed)));
   endfunction

   // ####################
   // timeout
   // ####################

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("checks %0d, errors %0d", n_checks, n_errors + 1);
         $display("Test failed");
         $finish;
      end
   end

   // ####################
   // test sequence
   // ####################

   initial begin
      logic [AW-1:0] a, b;
      logic [DW-1:0] exp;
      int            total;
      cmd_req    = 1'b0;
      cmd_op     = op_write;
      cmd_addr   = '0;
      cmd_wem    = '0;
      cmd_din    = '0;
      rsp_ack    = 1'b0;
      bist_start = 1'b0;
      wait (rst_n);
      next_cycle();

      // full words, every address defined first
      for (int i = 0; i < DEPTH; i++) send_cmd(op_write, AW'(i), '1, $random(seed));
      for (int i = 0; i < NUM_RAND; i++) begin
         a = rand_addr();
         send_cmd(op_write, a, '1, $random(seed));
         read_check("full_word", a);
      end

      // per-bit masks
      for (int i = 0; i < NUM_RAND; i++) begin
         a = rand_addr();
         send_cmd(op_write, a, $random(seed), $random(seed));
         read_check("masked_write", a);
      end

      // idle read latency
      repeat (2) next_cycle();
      a = rand_addr();
      send_cmd(op_read, a, '0, '0);
      collect_rsp("idle_read", model[a], 1'b1);

      // write overlapping a pending response
      for (int i = 0; i < NUM_PIPE; i++) begin
         a = rand_addr();
         b = (i % 2) ? a : rand_addr();   // same word every other round
         send_cmd(op_read, a, '0, '0);
         exp = model[a];                  // value before the write
         send_cmd(op_write, b, $random(seed), $random(seed));
         collect_rsp("pipe_read", exp, 1'b0);
         read_check("pipe_write", b);
      end

      // bist on a filled array
      for (int i = 0; i < DEPTH; i++) send_cmd(op_write, AW'(i), '1, $random(seed));
      start_bist();
      finish_bist();
      for (int i = 0; i < DEPTH; i++) read_check("bist_zero", AW'(i));

      // commands held off by bist
      start_bist();
      check("done_cleared", 0, DW'(bist_done));   // previous done drops at start
      a = rand_addr();
      send_cmd(op_write, a, $random(seed), $random(seed));
      finish_bist();
      read_check("held_write", a);
      start_bist();
      check("done_cleared", 0, DW'(bist_done));
      a = rand_addr();
      send_cmd(op_read, a, '0, '0);
      collect_rsp("held_read", model[a], 1'b0);
      finish_bist();

      repeat (2) next_cycle();
      total = n_errors + dut.u_chk.n_fails;
      $display("checks %0d, errors %0d, assertion failures %0d",
               n_checks, n_errors, dut.u_chk.n_fails);
      if (total == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : mem_subsys_tb

//--- vlog.f
verilog/mem_cfg_pkg.sv
verilog/mem_ctrl_pkg.sv
verilog/memory_ram.sv
verilog/memory_dp.sv
verilog/cmd_stage.sv
verilog/bist_march.sv
verilog/read_return.sv
verilog/mem_subsys_top.sv
verification/tb_clkgen.sv
verification/mem_subsys_chk.sv
verification/mem_subsys_tb.sv
